// ==== project.f ====
src/soc_pkg.sv
src/rw_axi_master.sv
src/axi_addr_router.sv
src/axi_ram_bridge.sv
src/clint_timer.sv
src/soc_mem_top.sv
dv/tb_soc_mem_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_soc_mem_top -f project.f || exit 1
out=$(./obj_dir/Vtb_soc_mem_top)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

// ==== dv/tb_soc_mem_top.sv ====
module tb_soc_mem_top import soc_pkg::*; ();

  localparam int TICK_DIV = 4;
  localparam int TIMEOUT  = 100; // clocks allowed per wait

  logic     clock;
  logic     rst_n;
  logic     rw_valid;
  logic     rw_we;
  addr_t    rw_addr;
  size_t    rw_size;
  data_t    rw_wdata;
  logic     rw_ready;
  data_t    rw_rdata;
  resp_t    rw_resp;
  addr_t    dmem_addr;
  data_t    dmem_wdata;
  dmem_op_t dmem_op;
  logic     dmem_we;
  data_t    dmem_rdata;
  logic     timer_irq;

  logic [7:0]  mem [0:4095]; // byte model, aliased on addr[11:0]
  logic [11:0] mem_a;
  int          errors;
  int          timeouts;
  integer      seed;

  soc_mem_top #(
    .TICK_DIV (TICK_DIV)
  ) u_soc_mem_top (
    .clock       (clock),
    .rst_n_i     (rst_n),
    .rw_valid_i  (rw_valid),
    .rw_we_i     (rw_we),
    .rw_addr_i   (rw_addr),
    .rw_size_i   (rw_size),
    .rw_wdata_i  (rw_wdata),
    .rw_ready_o  (rw_ready),
    .rw_rdata_o  (rw_rdata),
    .rw_resp_o   (rw_resp),
    .dmem_addr_o (dmem_addr),
    .dmem_data_o (dmem_wdata),
    .dmem_op_o   (dmem_op),
    .dmem_we_o   (dmem_we),
    .dmem_data_i (dmem_rdata),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // combinational word read, little endian
  assign mem_a      = dmem_addr[11:0];
  assign dmem_rdata = {mem[{mem_a[11:2], 2'd3}], mem[{mem_a[11:2], 2'd2}],
                       mem[{mem_a[11:2], 2'd1}], mem[{mem_a[11:2], 2'd0}]};

  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8);
    end
  end

  always @(posedge clock) begin
    if (dmem_we) begin
      case (dmem_op)
        DMEM_SB: mem[mem_a] <= dmem_wdata[7:0];
        DMEM_SH: begin
          mem[mem_a]         <= dmem_wdata[7:0];
          mem[mem_a + 12'd1] <= dmem_wdata[15:8];
        end
        default: begin
          mem[{mem_a[11:2], 2'd0}] <= dmem_wdata[7:0];
          mem[{mem_a[11:2], 2'd1}] <= dmem_wdata[15:8];
          mem[{mem_a[11:2], 2'd2}] <= dmem_wdata[23:16];
          mem[{mem_a[11:2], 2'd3}] <= dmem_wdata[31:24];
        end
      endcase
    end
  end

  function automatic addr_t clint_addr(input logic [CLINT_SPAN_BITS-1:0] ofs);
    return {CLINT_BASE[31:CLINT_SPAN_BITS], ofs};
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_irq(input logic exp);
    if (timer_irq !== exp) begin
      errors++;
      $display("MISMATCH at %0t: timer_irq_o got %b expected %b", $time, timer_irq, exp);
    end
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input size_t size,
                            input data_t wdata, output data_t rdata, output resp_t resp);
    int cnt;
    @(negedge clock);
    rw_valid = 1'b1;
    rw_we    = we;
    rw_addr  = addr;
    rw_size  = size;
    rw_wdata = wdata;
    cnt      = 0;
    while (!rw_ready && cnt < TIMEOUT) begin
      @(negedge clock);
      cnt++;
    end
    if (!rw_ready) begin
      timeouts++;
      $display("timeout at %0t: no rw_ready_o for the access to %h", $time, addr);
    end
    rdata    = rw_rdata;
    resp     = rw_resp;
    rw_valid = 1'b0;
  endtask

  task automatic ram_word_rw();
    data_t rdata;
    resp_t resp;
    bus_access(1'b1, 32'h0000_0100, SIZE_W, 32'hCAFE_F00D, rdata, resp);
    check_resp("rw_resp_o", resp, RESP_OKAY);
    bus_access(1'b0, 32'h0000_0100, SIZE_W, '0, rdata, resp);
    check_data("rw_rdata_o", rdata, 32'hCAFE_F00D);
    check_resp("rw_resp_o", resp, RESP_OKAY);
  endtask

  task automatic sub_word_merge();
    data_t base;
    data_t byte_d;
    data_t half_d;
    data_t rdata;
    resp_t resp;
    base   = 32'h1122_3344;
    byte_d = 32'hFFFF_FF5A; // only the low byte lands
    half_d = 32'hEEEE_9876;
    bus_access(1'b1, 32'h0000_0200, SIZE_W, base, rdata, resp);
    bus_access(1'b1, 32'h0000_0201, SIZE_B, byte_d, rdata, resp);
    bus_access(1'b1, 32'h0000_0202, SIZE_H, half_d, rdata, resp);
    bus_access(1'b0, 32'h0000_0200, SIZE_W, '0, rdata, resp);
    check_data("rw_rdata_o", rdata, {half_d[15:0], byte_d[7:0], base[7:0]});
  endtask

  task automatic timer_irq_levels();
    data_t rdata;
    resp_t resp;
    check_irq(1'b0);
    bus_access(1'b1, clint_addr(MTIMECMP_LO_OFS), SIZE_W, '0, rdata, resp);
    bus_access(1'b1, clint_addr(MTIMECMP_HI_OFS), SIZE_W, '0, rdata, resp);
    check_resp("rw_resp_o", resp, RESP_OKAY);
    repeat (2) @(negedge clock); // irq is registered
    check_irq(1'b1);
    bus_access(1'b0, clint_addr(MTIMECMP_LO_OFS), SIZE_W, '0, rdata, resp);
    check_data("mtimecmp_lo", rdata, 32'h0);
    bus_access(1'b0, clint_addr(MTIMECMP_HI_OFS), SIZE_W, '0, rdata, resp);
    check_data("mtimecmp_hi", rdata, 32'h0);
    bus_access(1'b1, clint_addr(MTIMECMP_LO_OFS), SIZE_W, '1, rdata, resp);
    bus_access(1'b1, clint_addr(MTIMECMP_HI_OFS), SIZE_W, '1, rdata, resp);
    repeat (2) @(negedge clock);
    check_irq(1'b0);
    bus_access(1'b0, clint_addr(MTIMECMP_LO_OFS), SIZE_W, '0, rdata, resp);
    check_data("mtimecmp_lo", rdata, 32'hFFFF_FFFF);
    bus_access(1'b0, clint_addr(MTIMECMP_HI_OFS), SIZE_W, '0, rdata, resp);
    check_data("mtimecmp_hi", rdata, 32'hFFFF_FFFF);
  endtask

  task automatic mtime_progress();
    data_t t0;
    data_t t1;
    resp_t resp;
    bus_access(1'b0, clint_addr(MTIME_LO_OFS), SIZE_W, '0, t0, resp);
    repeat (10 * TICK_DIV + 1) @(negedge clock);
    bus_access(1'b0, clint_addr(MTIME_LO_OFS), SIZE_W, '0, t1, resp);
    if (!(t1 > t0)) begin
      errors++;
      $display("mtime low did not advance at %0t: read %h then %h", $time, t0, t1);
    end
    bus_access(1'b1, clint_addr(MTIME_LO_OFS), SIZE_W, 32'h0001_0000, t0, resp);
    bus_access(1'b0, clint_addr(MTIME_LO_OFS), SIZE_W, '0, t1, resp);
    if (t1 < 32'h0001_0000) begin
      errors++;
      $display("mtime low read back %h, below the written 00010000 at %0t", t1, $time);
    end
  endtask

  task automatic clint_error_resp();
    data_t rdata;
    resp_t resp;
    bus_access(1'b0, clint_addr(16'h0000), SIZE_W, '0, rdata, resp);
    check_resp("rw_resp_o", resp, RESP_SLVERR);
    bus_access(1'b1, clint_addr(MTIMECMP_LO_OFS), SIZE_B, '0, rdata, resp);
    check_resp("rw_resp_o", resp, RESP_SLVERR);
    bus_access(1'b0, clint_addr(MTIMECMP_LO_OFS), SIZE_W, '0, rdata, resp);
    check_data("mtimecmp_lo", rdata, 32'hFFFF_FFFF);
  endtask

  task automatic random_ram_fill();
    addr_t addrs [0:19];
    data_t exp_mem [0:1023]; // last write wins, same aliasing as the model
    data_t wdata;
    data_t rdata;
    resp_t resp;
    for (int i = 0; i < 20; i++) begin
      addrs[i] = addr_t'($random(seed)) & 32'h0000_0FFC;
      wdata    = $random(seed);
      exp_mem[addrs[i][11:2]] = wdata;
      bus_access(1'b1, addrs[i], SIZE_W, wdata, rdata, resp);
      check_resp("rw_resp_o", resp, RESP_OKAY);
    end
    for (int i = 0; i < 20; i++) begin
      bus_access(1'b0, addrs[i], SIZE_W, '0, rdata, resp);
      check_data("rw_rdata_o", rdata, exp_mem[addrs[i][11:2]]);
    end
  endtask

  initial begin
    errors   = 0;
    timeouts = 0;
    seed     = 68733;
    rst_n    = 1'b0;
    rw_valid = 1'b0;
    rw_we    = 1'b0;
    rw_addr  = '0;
    rw_size  = SIZE_W;
    rw_wdata = '0;
    repeat (10) @(negedge clock);
    rst_n = 1'b1;
    ram_word_rw();
    sub_word_merge();
    timer_irq_levels();
    mtime_progress();
    clint_error_resp();
    random_ram_fill();
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src/soc_mem_top.sv ====
module soc_mem_top import soc_pkg::*; #(
  parameter int TICK_DIV = 4
) (
  input  logic     clock,
  input  logic     rst_n_i,
  input  logic     rw_valid_i,
  input  logic     rw_we_i,
  input  addr_t    rw_addr_i,
  input  size_t    rw_size_i,
  input  data_t    rw_wdata_i,
  output logic     rw_ready_o,
  output data_t    rw_rdata_o,
  output resp_t    rw_resp_o,
  output addr_t    dmem_addr_o,
  output data_t    dmem_data_o,
  output dmem_op_t dmem_op_o,
  output logic     dmem_we_o,
  input  data_t    dmem_data_i,
  output logic     timer_irq_o
);

  axi_req_t mst_req, ram_req, clint_req;
  axi_rsp_t mst_rsp, ram_rsp, clint_rsp;

  rw_axi_master u_master (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .rw_valid_i (rw_valid_i),
    .rw_we_i    (rw_we_i),
    .rw_addr_i  (rw_addr_i),
    .rw_size_i  (rw_size_i),
    .rw_wdata_i (rw_wdata_i),
    .rw_ready_o (rw_ready_o),
    .rw_rdata_o (rw_rdata_o),
    .rw_resp_o  (rw_resp_o),
    .bus_req_o  (mst_req),
    .bus_rsp_i  (mst_rsp)
  );

  axi_addr_router u_router (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .mst_req_i   (mst_req),
    .mst_rsp_o   (mst_rsp),
    .ram_req_o   (ram_req),
    .ram_rsp_i   (ram_rsp),
    .clint_req_o (clint_req),
    .clint_rsp_i (clint_rsp)
  );

  axi_ram_bridge u_ram (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (ram_req),
    .bus_rsp_o   (ram_rsp),
    .dmem_addr_o (dmem_addr_o),
    .dmem_data_o (dmem_data_o),
    .dmem_op_o   (dmem_op_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_data_i (dmem_data_i)
  );

  clint_timer #(
    .TICK_DIV (TICK_DIV)
  ) u_clint (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (clint_req),
    .bus_rsp_o   (clint_rsp),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== src/clint_timer.sv ====
module clint_timer import soc_pkg::*; #(
  parameter int TICK_DIV = 4
) (
  input  logic     clock,
  input  logic     rst_n_i,
  input  axi_req_t bus_req_i,
  output axi_rsp_t bus_rsp_o,
  output logic     timer_irq_o
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CNT_W-1:0]           tick_cnt_q;
  logic                       tick;
  logic [63:0]                mtime_q;
  logic [63:0]                mtimecmp_q;
  logic                       irq_q;
  logic                       b_valid_q;
  logic                       r_valid_q;
  resp_t                      b_resp_q;
  resp_t                      r_resp_q;
  data_t                      r_data_q;
  logic                       busy;
  logic                       wr_acc;
  logic                       rd_acc;
  logic                       wr_ok;
  logic                       rd_ok;
  logic [CLINT_SPAN_BITS-1:0] wr_ofs;
  logic [CLINT_SPAN_BITS-1:0] rd_ofs;
  data_t                      rd_word;

  assign tick   = tick_cnt_q == CNT_W'(TICK_DIV - 1);
  assign busy   = b_valid_q || r_valid_q;
  assign wr_acc = bus_req_i.aw_valid && bus_req_i.w_valid && !busy;
  assign rd_acc = bus_req_i.ar_valid && !busy;
  assign wr_ofs = bus_req_i.aw_addr[CLINT_SPAN_BITS-1:0];
  assign rd_ofs = bus_req_i.ar_addr[CLINT_SPAN_BITS-1:0];

  // mtime high is read only
  assign wr_ok = (bus_req_i.aw_size == SIZE_W) &&
                 (wr_ofs == MTIMECMP_LO_OFS || wr_ofs == MTIMECMP_HI_OFS ||
                  wr_ofs == MTIME_LO_OFS);

  always_comb begin
    rd_ok   = bus_req_i.ar_size == SIZE_W;
    rd_word = '0;
    case (rd_ofs)
      MTIMECMP_LO_OFS: rd_word = mtimecmp_q[31:0];
      MTIMECMP_HI_OFS: rd_word = mtimecmp_q[63:32];
      MTIME_LO_OFS:    rd_word = mtime_q[31:0];
      MTIME_HI_OFS:    rd_word = mtime_q[63:32];
      default:         rd_ok = 1'b0;
    endcase
  end

  always_comb begin
    bus_rsp_o.aw_ready = wr_acc;
    bus_rsp_o.w_ready  = wr_acc;
    bus_rsp_o.b_valid  = b_valid_q;
    bus_rsp_o.b_resp   = b_resp_q;
    bus_rsp_o.ar_ready = rd_acc;
    bus_rsp_o.r_valid  = r_valid_q;
    bus_rsp_o.r_data   = r_data_q;
    bus_rsp_o.r_resp   = r_resp_q;
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tick_cnt_q <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1; // irq stays low out of reset
      irq_q      <= 1'b0;
      b_valid_q  <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;
      if (wr_acc && wr_ok && wr_ofs == MTIME_LO_OFS) begin
        mtime_q <= {mtime_q[63:32], bus_req_i.w_data}; // write beats the tick
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_acc && wr_ok && wr_ofs == MTIMECMP_LO_OFS) mtimecmp_q[31:0] <= bus_req_i.w_data;
      if (wr_acc && wr_ok && wr_ofs == MTIMECMP_HI_OFS) mtimecmp_q[63:32] <= bus_req_i.w_data;
      irq_q <= mtime_q >= mtimecmp_q;
      if (wr_acc) b_valid_q <= 1'b1;
      else if (bus_req_i.b_ready) b_valid_q <= 1'b0;
      if (rd_acc) r_valid_q <= 1'b1;
      else if (bus_req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_acc) b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    if (rd_acc) begin
      r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      r_data_q <= rd_word;
    end
  end

  assign timer_irq_o = irq_q;

  a_one_resp: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(b_valid_q && r_valid_q));

endmodule

// ==== src/axi_ram_bridge.sv ====
module axi_ram_bridge import soc_pkg::*; (
  input  logic     clock,
  input  logic     rst_n_i,
  input  axi_req_t bus_req_i,
  output axi_rsp_t bus_rsp_o,
  output addr_t    dmem_addr_o,
  output data_t    dmem_data_o,
  output dmem_op_t dmem_op_o,
  output logic     dmem_we_o,
  input  data_t    dmem_data_i
);

  logic  b_valid_q;
  logic  r_valid_q;
  data_t r_data_q;
  logic  busy;
  logic  wr_acc;
  logic  rd_acc;
  size_t op_size;

  assign busy   = b_valid_q || r_valid_q; // response still held
  assign wr_acc = bus_req_i.aw_valid && bus_req_i.w_valid && !busy;
  assign rd_acc = bus_req_i.ar_valid && !busy;

  always_comb begin
    bus_rsp_o.aw_ready = wr_acc;
    bus_rsp_o.w_ready  = wr_acc;
    bus_rsp_o.b_valid  = b_valid_q;
    bus_rsp_o.b_resp   = RESP_OKAY;
    bus_rsp_o.ar_ready = rd_acc;
    bus_rsp_o.r_valid  = r_valid_q;
    bus_rsp_o.r_data   = r_data_q;
    bus_rsp_o.r_resp   = RESP_OKAY;
  end

  assign dmem_addr_o = bus_req_i.ar_valid ? bus_req_i.ar_addr : bus_req_i.aw_addr;
  assign op_size     = bus_req_i.ar_valid ? bus_req_i.ar_size : bus_req_i.aw_size;
  assign dmem_data_o = bus_req_i.w_data; // low bits, memory does the placing
  assign dmem_we_o   = wr_acc;

  always_comb begin
    case (op_size)
      SIZE_B:  dmem_op_o = DMEM_SB;
      SIZE_H:  dmem_op_o = DMEM_SH;
      default: dmem_op_o = DMEM_SW;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_acc) b_valid_q <= 1'b1;
      else if (bus_req_i.b_ready) b_valid_q <= 1'b0;
      if (rd_acc) r_valid_q <= 1'b1;
      else if (bus_req_i.r_ready) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_acc) r_data_q <= dmem_data_i; // word holding dmem_addr_o
  end

  a_we_single: assert property (@(posedge clock) disable iff (!rst_n_i)
    dmem_we_o |=> !dmem_we_o);

endmodule

// ==== src/axi_addr_router.sv ====
module axi_addr_router import soc_pkg::*; (
  input  logic     clock,
  input  logic     rst_n_i,
  input  axi_req_t mst_req_i,
  output axi_rsp_t mst_rsp_o,
  output axi_req_t ram_req_o,
  input  axi_rsp_t ram_rsp_i,
  output axi_req_t clint_req_o,
  input  axi_rsp_t clint_rsp_i
);

  localparam int AW = $bits(addr_t);

  addr_t    dec_addr;
  logic     sel_clint;
  logic     tgt_clint_q; // owner of the pending b/r response
  logic     accept;
  axi_rsp_t addr_src;
  axi_rsp_t resp_src;

  // aw_addr stays on the bus while w is still pending
  assign dec_addr  = mst_req_i.ar_valid ? mst_req_i.ar_addr : mst_req_i.aw_addr;
  assign sel_clint = dec_addr[AW-1:CLINT_SPAN_BITS] == CLINT_BASE[AW-1:CLINT_SPAN_BITS];

  always_comb begin
    ram_req_o          = mst_req_i;
    ram_req_o.aw_valid = mst_req_i.aw_valid && !sel_clint;
    ram_req_o.w_valid  = mst_req_i.w_valid && !sel_clint;
    ram_req_o.ar_valid = mst_req_i.ar_valid && !sel_clint;
    ram_req_o.b_ready  = mst_req_i.b_ready && !tgt_clint_q;
    ram_req_o.r_ready  = mst_req_i.r_ready && !tgt_clint_q;
  end

  always_comb begin
    clint_req_o          = mst_req_i;
    clint_req_o.aw_valid = mst_req_i.aw_valid && sel_clint;
    clint_req_o.w_valid  = mst_req_i.w_valid && sel_clint;
    clint_req_o.ar_valid = mst_req_i.ar_valid && sel_clint;
    clint_req_o.b_ready  = mst_req_i.b_ready && tgt_clint_q;
    clint_req_o.r_ready  = mst_req_i.r_ready && tgt_clint_q;
  end

  assign addr_src = sel_clint ? clint_rsp_i : ram_rsp_i;
  assign resp_src = tgt_clint_q ? clint_rsp_i : ram_rsp_i;

  always_comb begin
    mst_rsp_o          = resp_src; // b and r follow the latched target
    mst_rsp_o.aw_ready = addr_src.aw_ready;
    mst_rsp_o.w_ready  = addr_src.w_ready;
    mst_rsp_o.ar_ready = addr_src.ar_ready;
  end

  assign accept = (mst_req_i.aw_valid && mst_rsp_o.aw_ready) ||
                  (mst_req_i.ar_valid && mst_rsp_o.ar_ready);

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tgt_clint_q <= 1'b0;
    end else if (accept) begin
      tgt_clint_q <= sel_clint;
    end
  end

  // only the latched target may hold a b or r response
  a_resp_from_target: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(tgt_clint_q ? (ram_rsp_i.b_valid || ram_rsp_i.r_valid)
                  : (clint_rsp_i.b_valid || clint_rsp_i.r_valid)));

endmodule

// ==== src/rw_axi_master.sv ====
module rw_axi_master import soc_pkg::*; (
  input  logic     clock,
  input  logic     rst_n_i,
  input  logic     rw_valid_i,
  input  logic     rw_we_i,
  input  addr_t    rw_addr_i,
  input  size_t    rw_size_i,
  input  data_t    rw_wdata_i,
  output logic     rw_ready_o,
  output data_t    rw_rdata_o,
  output resp_t    rw_resp_o,
  output axi_req_t bus_req_o,
  input  axi_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_RESP,
    ST_DONE
  } state_t;

  state_t state_q;
  logic   aw_valid_q;
  logic   w_valid_q;
  logic   ar_valid_q;
  logic   ready_q;
  logic   we_q;
  addr_t  addr_q;
  size_t  size_q;
  data_t  wdata_q;
  data_t  rdata_q;
  resp_t  resp_q;
  logic   resp_wait;
  logic   aw_hs, w_hs, ar_hs, b_hs, r_hs;
  logic   addr_done;

  assign resp_wait = (state_q == ST_RESP) && !ready_q;

  assign aw_hs = aw_valid_q && bus_rsp_i.aw_ready;
  assign w_hs  = w_valid_q && bus_rsp_i.w_ready;
  assign ar_hs = ar_valid_q && bus_rsp_i.ar_ready;
  assign b_hs  = resp_wait && bus_rsp_i.b_valid;
  assign r_hs  = resp_wait && bus_rsp_i.r_valid;

  // a write is done once both aw and w are taken, in any order
  assign addr_done = we_q ? ((!aw_valid_q || aw_hs) && (!w_valid_q || w_hs)) : ar_hs;

  always_comb begin
    bus_req_o.aw_valid = aw_valid_q;
    bus_req_o.aw_addr  = addr_q;
    bus_req_o.aw_size  = size_q;
    bus_req_o.w_valid  = w_valid_q;
    bus_req_o.w_data   = wdata_q;
    bus_req_o.b_ready  = resp_wait;
    bus_req_o.ar_valid = ar_valid_q;
    bus_req_o.ar_addr  = addr_q;
    bus_req_o.ar_size  = size_q;
    bus_req_o.r_ready  = resp_wait;
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      ar_valid_q <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rw_valid_i) begin
            aw_valid_q <= rw_we_i;
            w_valid_q  <= rw_we_i;
            ar_valid_q <= !rw_we_i;
            state_q    <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (aw_hs) aw_valid_q <= 1'b0;
          if (w_hs) w_valid_q <= 1'b0;
          if (ar_hs) ar_valid_q <= 1'b0;
          if (addr_done) state_q <= ST_RESP;
        end
        ST_RESP: begin
          if (ready_q) state_q <= ST_DONE; // pulse just went out
          else if (we_q ? b_hs : r_hs) ready_q <= 1'b1;
        end
        default: state_q <= ST_IDLE; // done, requester drops valid here
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && rw_valid_i) begin
      we_q    <= rw_we_i;
      addr_q  <= rw_addr_i;
      size_q  <= rw_size_i;
      wdata_q <= rw_wdata_i;
    end
    if (b_hs && we_q) resp_q <= bus_rsp_i.b_resp;
    if (r_hs && !we_q) begin
      resp_q  <= bus_rsp_i.r_resp;
      rdata_q <= bus_rsp_i.r_data;
    end
  end

  assign rw_ready_o = ready_q;
  assign rw_rdata_o = rdata_q;
  assign rw_resp_o  = resp_q;

  a_no_aw_with_ar: assert property (@(posedge clock) disable iff (!rst_n_i)
    !(bus_req_o.aw_valid && bus_req_o.ar_valid));

endmodule

// ==== src/soc_pkg.sv ====
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } size_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_t;

  // naive data-memory op encoding
  typedef enum logic [2:0] {
    DMEM_SB = 3'd0,
    DMEM_SH = 3'd1,
    DMEM_SW = 3'd2
  } dmem_op_t;

  // master to slave
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    size_t aw_size;
    logic  w_valid;
    data_t w_data;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    size_t ar_size;
    logic  r_ready;
  } axi_req_t;

  // slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_t b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_t r_resp;
  } axi_rsp_t;

  localparam addr_t CLINT_BASE      = 32'h0200_0000;
  localparam int    CLINT_SPAN_BITS = 16; // 64 KiB window

  // offsets inside the clint window
  localparam logic [CLINT_SPAN_BITS-1:0] MTIMECMP_LO_OFS = 16'h4000;
  localparam logic [CLINT_SPAN_BITS-1:0] MTIMECMP_HI_OFS = 16'h4004;
  localparam logic [CLINT_SPAN_BITS-1:0] MTIME_LO_OFS    = 16'hBFF8;
  localparam logic [CLINT_SPAN_BITS-1:0] MTIME_HI_OFS    = 16'hBFFC;

endpackage
